//--- common/data_mem_params.svh
`ifndef DATA_MEM_PARAMS_SVH
`define DATA_MEM_PARAMS_SVH

// number of 32-bit words in the data memory.
// word addresses wrap modulo this depth.
`define DMEM_WORDS 16

// entries in each in-order buffer.
// this also bounds the number of loads in flight.
`define REQ_FIFO_DEPTH 4

`endif

//--- common/mem_bus_pkg.sv
// types of the word-wide memory bus between the request buffer and the memory.
// the bus carries whole 32-bit words, and byte lanes are picked by the enables.
package mem_bus_pkg;

	// one data word as stored in the memory array.
	typedef logic [31:0] word_t;

	// byte enables.
	// bit n selects bits 8n+7 down to 8n of the word.
	typedef logic [3:0] be_t;

	// one buffered request as it waits in the request buffer.
	// the address is a word address, already shifted down by two.
	// for a read the write data is don't-care, but it is still carried.
	typedef struct packed {
		// high for a store, low for a load.
		logic  we;
		// lanes touched by the access.
		be_t   be;
		// word address, only the low bits that index the memory are used.
		logic [31:0] addr;
		// lane-copied store data.
		word_t wdata;
	} mem_req_t;

	// 1 + 4 + 32 + 32 bits, 69 in all.

endpackage

//--- common/lsu_pkg.sv
// types of the load/store side.
// they describe the operations the core issues and what the unit keeps per load.
package lsu_pkg;

	// load and store operations, RISC-V style.
	// the u variants zero-extend, the others sign-extend.
	typedef enum logic [2:0] {
		LB,
		LH,
		LW,
		LBU,
		LHU,
		SB,
		SH,
		SW
	} lsu_op_e;

	// what must be remembered about a load until its response comes back.
	// the offset picks the byte or halfword inside the returned word.
	typedef struct packed {
		// the load operation, for the size and the extension.
		lsu_op_e    op;
		// byte offset inside the word, from address bits 1:0.
		logic [1:0] offset;
	} load_tag_t;

	// 3 + 2 bits, 5 in all.

endpackage

//--- design/req_fifo.sv
`timescale 1ns/1ns

module req_fifo #(
	parameter int  DEPTH     = 4,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push_i,
	input  payload_t data_i,
	input  logic     pop_i,
	output payload_t data_o,
	output logic     empty_o,
	output logic     full_o
);

	// pointer and count widths.
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t        mem_q [DEPTH];
	logic [PW-1:0]   wr_ptr_q;
	logic [PW-1:0]   rd_ptr_q;
	logic [CW-1:0]   count_q;
	logic            do_push;
	logic            do_pop;

	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == CW'(DEPTH));

	// a push into a full buffer only goes through when the head leaves that same edge.
	assign do_pop  = pop_i && !empty_o;
	assign do_push = push_i && (!full_o || do_pop);

	// head entry, visible the cycle after its push.
	assign data_o = mem_q[rd_ptr_q];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			// count only moves when exactly one side is active.
			if (do_push && !do_pop) begin
				count_q <= count_q + 1'b1;
			end else if (do_pop && !do_push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// storage.
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= data_i;
		end
	end

endmodule

//--- data_mem/data_mem_core.sv
`timescale 1ns/1ns

module data_mem_core #(
	parameter int WORDS = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_i,
	input  logic               block_i,
	input  mem_bus_pkg::be_t   be_i,
	input  logic [31:0]        addr_i,
	input  logic               we_i,
	input  mem_bus_pkg::word_t wdata_i,
	output logic               gnt_o,
	output logic               rvalid_o,
	output mem_bus_pkg::word_t rdata_o
);

	import mem_bus_pkg::*;

	// index width, the upper address bits wrap.
	localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

	word_t         mem_q [WORDS];
	logic [AW-1:0] idx;
	word_t         rd_masked;
	logic          rd_gnt;
	logic          wr_gnt;

	assign idx = addr_i[AW-1:0];

	// grant as soon as the request is there.
	// block stands for another master owning the bank.
	assign gnt_o  = req_i && !block_i;
	assign rd_gnt = gnt_o && !we_i;
	assign wr_gnt = gnt_o && we_i;

	// disabled lanes read back as zero.
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			rd_masked[8*b +: 8] = be_i[b] ? mem_q[idx][8*b +: 8] : 8'h00;
		end
	end

	// write only the enabled bytes at the granted edge.
	// reads capture the word at their grant.
	always_ff @(posedge clk) begin
		if (wr_gnt) begin
			for (int b = 0; b < 4; b++) begin
				if (be_i[b]) begin
					mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
		if (rd_gnt) begin
			rdata_o <= rd_masked;
		end
	end

	// rvalid is a one-cycle strobe after each granted read.
	// writes get no response.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid_o <= 1'b0;
		end else begin
			rvalid_o <= rd_gnt;
		end
	end

endmodule

//--- lsu/load_store_unit.sv
`timescale 1ns/1ns

`include "data_mem_params.svh"

module load_store_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 op_valid_i,
	input  lsu_pkg::lsu_op_e     op_i,
	input  logic [31:0]          addr_i,
	input  mem_bus_pkg::word_t   wdata_i,
	output logic                 op_ready_o,
	output logic                 req_push_o,
	output mem_bus_pkg::mem_req_t req_o,
	input  logic                 req_full_i,
	input  logic                 rvalid_i,
	input  mem_bus_pkg::word_t   rdata_i,
	output logic                 load_valid_o,
	output mem_bus_pkg::word_t   load_data_o
);

	import lsu_pkg::*;
	import mem_bus_pkg::*;

	logic      accept;
	logic      is_load;
	logic [1:0] offset;
	be_t       be;
	word_t     wdata_lanes;
	logic      tag_push;
	load_tag_t tag_in;
	load_tag_t tag_head;
	logic      tag_empty;
	logic      tag_full;
	logic [7:0]  rd_byte;
	logic [15:0] rd_half;

	// both the request buffer and the tag buffer must have room.
	assign op_ready_o = !req_full_i && !tag_full;
	assign accept     = op_valid_i && op_ready_o;
	assign offset     = addr_i[1:0];

	// byte enables and lane copies follow the access size.
	// misaligned low bits are simply ignored.
	always_comb begin
		is_load     = 1'b1;
		be          = 4'b1111;
		wdata_lanes = wdata_i;
		case (op_i)
			LB, LBU, SB: begin
				be          = be_t'(4'b0001 << offset);
				wdata_lanes = {4{wdata_i[7:0]}};
			end
			LH, LHU, SH: begin
				be          = addr_i[1] ? 4'b1100 : 4'b0011;
				wdata_lanes = {2{wdata_i[15:0]}};
			end
			default: begin
				be          = 4'b1111;
				wdata_lanes = wdata_i;
			end
		endcase
		if (op_i inside {SB, SH, SW}) begin
			is_load = 1'b0;
		end
	end

	// one memory request per accepted operation.
	assign req_push_o  = accept;
	assign req_o.we    = !is_load;
	assign req_o.be    = be;
	assign req_o.addr  = {2'b00, addr_i[31:2]};
	assign req_o.wdata = wdata_lanes;

	// loads also leave a tag, so the response can be shaped later.
	assign tag_push      = accept && is_load;
	assign tag_in.op     = op_i;
	assign tag_in.offset = offset;

	// tag buffer, popped by each read response.
	req_fifo #(
		.DEPTH     (`REQ_FIFO_DEPTH),
		.payload_t (load_tag_t)
	) i_tag_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.push_i  (tag_push),
		.data_i  (tag_in),
		.pop_i   (rvalid_i),
		.data_o  (tag_head),
		.empty_o (tag_empty),
		.full_o  (tag_full)
	);

	// pick the addressed field out of the returned word.
	// halfwords only look at bit 1 of the offset.
	assign rd_byte = rdata_i[8*tag_head.offset +: 8];
	assign rd_half = rdata_i[16*tag_head.offset[1] +: 16];

	// a response with no tag waiting would be a protocol fault, so it is not passed on.
	assign load_valid_o = rvalid_i && !tag_empty;

	always_comb begin
		case (tag_head.op)
			LB:      load_data_o = {{24{rd_byte[7]}}, rd_byte};
			LBU:     load_data_o = {24'h00_0000, rd_byte};
			LH:      load_data_o = {{16{rd_half[15]}}, rd_half};
			LHU:     load_data_o = {16'h0000, rd_half};
			default: load_data_o = rdata_i;
		endcase
	end

endmodule

//--- design/data_mem_subsys.sv
`timescale 1ns/1ns

`include "data_mem_params.svh"

module data_mem_subsys (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               op_valid_i,
	input  lsu_pkg::lsu_op_e   op_i,
	input  logic [31:0]        addr_i,
	input  mem_bus_pkg::word_t wdata_i,
	output logic               op_ready_o,
	input  logic               mem_block_i,
	output logic               load_valid_o,
	output mem_bus_pkg::word_t load_data_o
);

	import mem_bus_pkg::*;

	// producer side of the request buffer.
	logic     req_push;
	mem_req_t req_new;
	logic     req_full;

	// consumer side, the head entry faces the memory.
	logic     req_empty;
	mem_req_t req_head;
	logic     req;
	logic     gnt;

	// read response.
	logic     rvalid;
	word_t    rdata;

	// the memory sees a request while the buffer holds anything.
	assign req = !req_empty;

	load_store_unit i_lsu (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_valid_i   (op_valid_i),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.op_ready_o   (op_ready_o),
		.req_push_o   (req_push),
		.req_o        (req_new),
		.req_full_i   (req_full),
		.rvalid_i     (rvalid),
		.rdata_i      (rdata),
		.load_valid_o (load_valid_o),
		.load_data_o  (load_data_o)
	);

	// pops on every grant.
	req_fifo #(
		.DEPTH     (`REQ_FIFO_DEPTH),
		.payload_t (mem_req_t)
	) i_req_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.push_i  (req_push),
		.data_i  (req_new),
		.pop_i   (gnt),
		.data_o  (req_head),
		.empty_o (req_empty),
		.full_o  (req_full)
	);

	data_mem_core #(
		.WORDS (`DMEM_WORDS)
	) i_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_i    (req),
		.block_i  (mem_block_i),
		.be_i     (req_head.be),
		.addr_i   (req_head.addr),
		.we_i     (req_head.we),
		.wdata_i  (req_head.wdata),
		.gnt_o    (gnt),
		.rvalid_o (rvalid),
		.rdata_o  (rdata)
	);

endmodule

//--- verif/data_mem_subsys_assertions.sv
`timescale 1ns/1ns

module data_mem_subsys_assertions (
	input logic clk,
	input logic rst_n,
	input logic req_i,
	input logic gnt_i,
	input logic we_i,
	input logic rvalid_i,
	input logic push_i,
	input logic op_ready_i
);

	// the memory only grants a pending request.
	gnt_needs_req: assert property (
		@(posedge clk) disable iff (!rst_n) gnt_i |-> req_i
	) else $error("grant seen without a request");

	// writes get no response, so rvalid stays low after a granted write.
	no_rvalid_after_write: assert property (
		@(posedge clk) disable iff (!rst_n) (gnt_i && we_i) |=> !rvalid_i
	) else $error("rvalid followed a granted write");

	// the load/store unit never pushes into a buffer that has no room.
	push_only_when_ready: assert property (
		@(posedge clk) disable iff (!rst_n) push_i |-> op_ready_i
	) else $error("request pushed while op_ready_o was low");

endmodule

// attached to every instance of the top level.
bind data_mem_subsys data_mem_subsys_assertions i_assertions (
	.clk        (clk),
	.rst_n      (rst_n),
	.req_i      (req),
	.gnt_i      (gnt),
	.we_i       (req_head.we),
	.rvalid_i   (rvalid),
	.push_i     (req_push),
	.op_ready_i (op_ready_o)
);

//--- verif/data_mem_subsys_tb.sv
`timescale 1ns/1ns

`include "data_mem_params.svh"

module data_mem_subsys_tb;

	import lsu_pkg::*;
	import mem_bus_pkg::*;

	localparam int MEM_BYTES      = `DMEM_WORDS * 4;
	localparam int TIMEOUT_CYCLES = 200;

	logic     clk;
	logic     rst_n;
	logic     op_valid_i;
	lsu_op_e  op_i;
	logic [31:0] addr_i;
	word_t    wdata_i;
	logic     op_ready_o;
	logic     mem_block_i;
	logic     load_valid_o;
	word_t    load_data_o;

	// byte-wide reference copy of the memory.
	logic [7:0]  model_mem [MEM_BYTES];
	// expected load results with the oldest first.
	word_t       expected_q [$];
	word_t       monitor_exp;
	int          error_count;
	int          load_count;
	logic [31:0] lcg_state;

	data_mem_subsys i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_valid_i   (op_valid_i),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.op_ready_o   (op_ready_o),
		.mem_block_i  (mem_block_i),
		.load_valid_o (load_valid_o),
		.load_data_o  (load_data_o)
	);

	// 8 ns period.
	always #4 clk = ~clk;

	// numerical recipes constants.
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic op_is_store(input lsu_op_e op);
		return (op == SB) || (op == SH) || (op == SW);
	endfunction

	// stores land at byte, halfword or word granularity.
	// the low bits that the size does not use are dropped.
	task automatic model_store(input lsu_op_e op, input logic [31:0] addr, input word_t wdata);
		int bi;
		bi = addr % MEM_BYTES;
		case (op)
			SB: model_mem[bi] = wdata[7:0];
			SH: begin
				bi = bi - (bi % 2);
				model_mem[bi]     = wdata[7:0];
				model_mem[bi + 1] = wdata[15:8];
			end
			default: begin
				bi = bi - (bi % 4);
				for (int k = 0; k < 4; k++) begin
					model_mem[bi + k] = wdata[8*k +: 8];
				end
			end
		endcase
	endtask

	// load result as the core expects it from the byte model.
	function automatic word_t model_load(input lsu_op_e op, input logic [31:0] addr);
		int         bi;
		int         hi;
		int         wi;
		logic [7:0] b;
		logic [15:0] h;
		word_t      w;
		bi = addr % MEM_BYTES;
		hi = bi - (bi % 2);
		wi = bi - (bi % 4);
		b  = model_mem[bi];
		h  = {model_mem[hi + 1], model_mem[hi]};
		w  = {model_mem[wi + 3], model_mem[wi + 2], model_mem[wi + 1], model_mem[wi]};
		case (op)
			LB:      return {{24{b[7]}}, b};
			LBU:     return {24'h0, b};
			LH:      return {{16{h[15]}}, h};
			LHU:     return {16'h0, h};
			default: return w;
		endcase
	endfunction

	// drive one operation from a falling edge and hold it until it is taken.
	// returns on the falling edge after the accepting rising edge.
	task automatic issue_op(input lsu_op_e op, input logic [31:0] addr, input word_t wdata);
		int waited;
		waited     = 0;
		op_valid_i = 1'b1;
		op_i       = op;
		addr_i     = addr;
		wdata_i    = wdata;
		while (!op_ready_o && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!op_ready_o) begin
			$display("Error at %0t: operation was never accepted", $time);
			error_count++;
		end else if (op_is_store(op)) begin
			model_store(op, addr, wdata);
		end else begin
			expected_q.push_back(model_load(op, addr));
		end
		@(negedge clk);
		op_valid_i = 1'b0;
	endtask

	// wait for every outstanding load result.
	task automatic wait_drain();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (expected_q.size() != 0) begin
			$display("Error at %0t: %0d load results never arrived", $time, expected_q.size());
			error_count++;
			expected_q.delete();
		end
		repeat (2) @(negedge clk);
	endtask

	// results are compared in acceptance order.
	// outputs only move at rising edges.
	always @(negedge clk) begin
		if (rst_n && load_valid_o) begin
			if (expected_q.size() == 0) begin
				$display("Error at %0t: load result with no load outstanding", $time);
				error_count++;
			end else begin
				monitor_exp = expected_q.pop_front();
				if (load_data_o !== monitor_exp) begin
					$display("Fail at %0t: load_data_o got %h expected %h", $time,
						load_data_o, monitor_exp);
					error_count++;
				end
				load_count++;
			end
		end
	end

	task automatic test_reset_state();
		@(negedge clk);
		if (op_ready_o !== 1'b1) begin
			$display("Fail at %0t: op_ready_o got %b expected 1", $time, op_ready_o);
			error_count++;
		end
		if (load_valid_o !== 1'b0) begin
			$display("Fail at %0t: load_valid_o got %b expected 0", $time, load_valid_o);
			error_count++;
		end
	endtask

	// fill every word through wrapping addresses and read back through others.
	task automatic test_word_path();
		for (int i = 0; i < `DMEM_WORDS; i++) begin
			issue_op(SW, (i + `DMEM_WORDS * (i % 3)) * 4, lcg_next());
		end
		for (int i = 0; i < `DMEM_WORDS; i++) begin
			issue_op(LW, i * 4 + MEM_BYTES * ((i + 1) % 2), 32'h0);
		end
		wait_drain();
		// with the bank free and the buffers empty the result shows one cycle later.
		issue_op(LW, 32'h0000_0020, 32'h0);
		if (load_valid_o !== 1'b0) begin
			$display("Fail at %0t: load_valid_o got %b expected 0", $time, load_valid_o);
			error_count++;
		end
		@(negedge clk);
		if (load_valid_o !== 1'b1) begin
			$display("Fail at %0t: load_valid_o got %b expected 1", $time, load_valid_o);
			error_count++;
		end
		wait_drain();
	endtask

	// word 4 gets bytes and word 5 gets halfwords.
	// both end up holding fields with the top bit set and fields with it clear.
	task automatic test_byte_enables();
		logic [7:0]  bytes [4];
		logic [15:0] halves [4];
		lsu_op_e     narrow [4];
		bytes  = '{8'hA5, 8'h3C, 8'hF0, 8'h0F};
		halves = '{16'h7FFE, 16'h8001, 16'hC0DE, 16'h1234};
		narrow = '{LB, LBU, LH, LHU};
		issue_op(SW, 32'h10, 32'h1234_5678);
		issue_op(SW, 32'h14, 32'h89AB_CDEF);
		for (int k = 0; k < 4; k++) begin
			issue_op(SB, 32'h10 + k, {24'hDEAD_BE, bytes[k]});
		end
		for (int k = 0; k < 4; k++) begin
			issue_op(SH, 32'h14 + k, {16'hFACE, halves[k]});
		end
		for (int w = 0; w < 2; w++) begin
			for (int k = 0; k < 4; k++) begin
				for (int n = 0; n < 4; n++) begin
					issue_op(narrow[n], 32'h10 + 4 * w + k, 32'h0);
				end
			end
		end
		wait_drain();
	endtask

	// a blocked bank fills the buffers.
	// stores count toward that as well as loads.
	task automatic test_back_pressure();
		lsu_op_e     ops [4];
		logic [31:0] addrs [4];
		int          seen;
		ops   = '{LW, SW, LH, LBU};
		addrs = '{32'h00, 32'h04, 32'h06, 32'h09};
		mem_block_i = 1'b1;
		for (int k = 0; k < `REQ_FIFO_DEPTH; k++) begin
			issue_op(ops[k], addrs[k], 32'hF00D_8421 + k);
			if (op_ready_o !== (k < `REQ_FIFO_DEPTH - 1)) begin
				$display("Fail at %0t: op_ready_o got %b expected %b", $time, op_ready_o,
					k < `REQ_FIFO_DEPTH - 1);
				error_count++;
			end
		end
		// a strobe while not ready is dropped and stays on the inputs.
		seen       = load_count;
		op_valid_i = 1'b1;
		op_i       = LW;
		addr_i     = 32'h04;
		repeat (3) begin
			@(negedge clk);
			if (op_ready_o !== 1'b0) begin
				$display("Fail at %0t: op_ready_o got %b expected 0", $time, op_ready_o);
				error_count++;
			end
		end
		if (load_count != seen) begin
			$display("Error at %0t: load result came out while the bank was blocked", $time);
			error_count++;
		end
		mem_block_i = 1'b0;
		issue_op(LW, 32'h04, 32'h0);
		wait_drain();
	endtask

	// random traffic with the bank blocked now and then.
	task automatic test_random_mix();
		lsu_op_e     op;
		logic [31:0] addr;
		word_t       wdata;
		for (int i = 0; i < 200; i++) begin
			op          = lsu_op_e'(lcg_next() >> 29);
			addr        = lcg_next();
			wdata       = lcg_next();
			mem_block_i = (lcg_next() >> 30) == 0;
			// full buffers would never drain under a held block.
			if (!op_ready_o) begin
				mem_block_i = 1'b0;
			end
			if ((lcg_next() >> 29) == 0) begin
				@(negedge clk);
			end
			issue_op(op, addr, wdata);
		end
		mem_block_i = 1'b0;
		wait_drain();
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		op_valid_i  = 1'b0;
		op_i        = LW;
		addr_i      = 32'h0;
		wdata_i     = 32'h0;
		mem_block_i = 1'b0;
		error_count = 0;
		load_count  = 0;
		lcg_state   = 32'h857e_06df;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		test_reset_state();
		test_word_path();
		test_byte_enables();
		test_back_pressure();
		test_random_mix();
		$display("errors: %0d, load results checked: %0d", error_count, load_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- data_mem_subsys.f
+incdir+common
common/mem_bus_pkg.sv
common/lsu_pkg.sv
design/req_fifo.sv
data_mem/data_mem_core.sv
lsu/load_store_unit.sv
design/data_mem_subsys.sv
verif/data_mem_subsys_assertions.sv
verif/data_mem_subsys_tb.sv

//--- Bender.yml
package:
  name: data_mem_subsys

export_include_dirs:
  - common

sources:
  - common/mem_bus_pkg.sv
  - common/lsu_pkg.sv
  - design/req_fifo.sv
  - data_mem/data_mem_core.sv
  - lsu/load_store_unit.sv
  - design/data_mem_subsys.sv
  - target: test
    files:
      - verif/data_mem_subsys_assertions.sv
      - verif/data_mem_subsys_tb.sv
